// ==== uartRx_params.svh ====
`ifndef UARTRX_PARAMS_SVH
`define UARTRX_PARAMS_SVH

// system clock in Hz
`define CLK_FREQ 1843200

// serial line rate in bits per second
`define BAUD 115200

// oversampling rate, 8 ticks per bit
`define BAUD8 (`BAUD * 8)

// fractional divider accumulator width
`define ACC_WIDTH 16

// increment added every clock
// rounded value of BAUD8 * 2**ACC_WIDTH / CLK_FREQ
// operands pre-scaled by 2**7 so the product fits in 32 bits
`define ACC_INC \
  ((((`BAUD8) << (`ACC_WIDTH - 7)) + (`CLK_FREQ >> 8)) / (`CLK_FREQ >> 7))

// spacing count at which a bit is sampled
// values 8 to 11 work on a clean line
`define SAMPLE_POINT 10

// idle ticks after reception that close a packet (two bit times)
`define GAP_TICKS 16

`endif

// ==== uartRxPkg.sv ====
package uartRxPkg;

  // one received data word
  typedef logic [7:0] byte_t;

  // oversample tick counter between samples
  // low 3 bits wrap every 8 ticks, bit 3 is sticky once set
  typedef logic [3:0] spacing_t;

  // idle tick counter for packet gap detection
  typedef logic [4:0] gapCnt_t;

  // receiver frame states
  typedef enum logic [1:0]
  {
    idle    = 2'd0,  // waiting for a start bit
    dataBit = 2'd1,  // sampling the eight data bits
    stopBit = 2'd2   // sampling the stop bit
  } rxState_e;

  // result of one frame, registered at the stop sample
  typedef struct packed
  {
    byte_t data;      // assembled byte, LSB received first
    logic  valid;     // one clock, stop bit read high
    logic  frameErr;  // one clock, stop bit read low
  } rxResult_t;

endpackage

// ==== baudTickGen.sv ====
`timescale 1ns/1ns
`include "uartRx_params.svh"

module baudTickGen
(
  input  logic clk,
  input  logic arstN,
  output logic tick  // one clock pulse, 8 per bit on average
);

  // one extra bit on top for the carry
  localparam int unsigned accW = `ACC_WIDTH;
  localparam logic [accW:0] accInc = (accW + 1)'(`ACC_INC);

  logic [accW:0] acc;  // acc[accW] holds last carry

  // carry is dropped before adding, so the remainder keeps
  // accumulating and the tick rate has no long term drift
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      acc <= '0;
    end
    else
    begin
      acc <= {1'b0, acc[accW-1:0]} + accInc;
    end
  end

  assign tick = acc[accW];  // carry out

endmodule

// ==== rxLineFilter.sv ====
`timescale 1ns/1ns

module rxLineFilter
(
  input  logic clk,
  input  logic arstN,
  input  logic tick,
  input  logic rx,       // raw async serial line, idles high
  output logic lineBit   // debounced and inverted, 1 while line is low
);

  logic [1:0] syncInv;  // synchronizer chain, carries ~rx
  logic [1:0] voteCnt;  // saturating vote counter

  // line is inverted at the input so that idle reads 0
  // and a cleared reset state never looks like a start bit
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      syncInv <= '0;
    end
    else if (tick)
    begin
      syncInv <= {syncInv[0], ~rx};  // only shifts on oversample ticks
    end
  end

  // counter drifts toward the synchronized level by one per tick
  // lineBit flips only at the rails, which gives hysteresis
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      voteCnt <= 2'd0;
      lineBit <= 1'b0;
    end
    else if (tick)
    begin
      if (syncInv[1] && (voteCnt != 2'd3))
        voteCnt <= voteCnt + 2'd1;  // line low, count up
      else if (!syncInv[1] && (voteCnt != 2'd0))
        voteCnt <= voteCnt - 2'd1;  // line high, count down

      if (voteCnt == 2'd3)
        lineBit <= 1'b1;
      else if (voteCnt == 2'd0)
        lineBit <= 1'b0;
      // counts 1 and 2 hold the previous level
    end
  end

endmodule

// ==== rxFrameFsm.sv ====
`timescale 1ns/1ns
`include "uartRx_params.svh"

module rxFrameFsm
(
  input  logic clk,
  input  logic arstN,
  input  logic tick,
  input  logic lineBit,  // debounced inverted line
  output logic shiftEn,  // data bit sample strobe
  output logic stopEn,   // stop bit sample strobe
  output logic busy      // frame in progress
);

  localparam uartRxPkg::spacing_t samplePoint = uartRxPkg::spacing_t'(`SAMPLE_POINT);

  uartRxPkg::rxState_e state;
  uartRxPkg::spacing_t spacing;   // ticks since start detection
  logic [2:0]          bitIdx;    // data bit being sampled
  logic                nextBit;   // spacing sits on the sample point
  logic                lineBitQ;  // lineBit as seen on the previous tick

  assign nextBit = (spacing == samplePoint);

  // first sample lands samplePoint ticks after start detection
  // once bit 3 is set the low bits wrap, so later samples are 8 ticks apart
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      spacing <= '0;
    end
    else if (state == uartRxPkg::idle)
    begin
      spacing <= '0;  // held clear between frames
    end
    else if (tick)
    begin
      spacing[2:0] <= spacing[2:0] + 3'd1;
      spacing[3]   <= spacing[3] | (spacing[2:0] == 3'd7);  // sticky after first wrap
    end
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state    <= uartRxPkg::idle;
      bitIdx   <= 3'd0;
      lineBitQ <= 1'b0;
    end
    else if (tick)
    begin
      lineBitQ <= lineBit;
      case (state)
        uartRxPkg::idle:
        begin
          // only a fresh falling line edge starts a frame
          // a line still held low after a bad stop bit is ignored
          if (lineBit && !lineBitQ)
          begin
            state  <= uartRxPkg::dataBit;
            bitIdx <= 3'd0;
          end
        end
        uartRxPkg::dataBit:
        begin
          if (nextBit)
          begin
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == 3'd7)
              state <= uartRxPkg::stopBit;  // last data bit taken
          end
        end
        uartRxPkg::stopBit:
        begin
          if (nextBit)
            state <= uartRxPkg::idle;  // stop sampled, hunt for next start
        end
        default:
        begin
          state <= uartRxPkg::idle;  // unused encoding
        end
      endcase
    end
  end

  assign shiftEn = tick && nextBit && (state == uartRxPkg::dataBit);
  assign stopEn  = tick && nextBit && (state == uartRxPkg::stopBit);
  assign busy    = (state != uartRxPkg::idle);

endmodule

// ==== rxByteShifter.sv ====
`timescale 1ns/1ns

module rxByteShifter
(
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 shiftEn,  // take one data bit
  input  logic                 stopEn,   // stop bit sample point
  input  logic                 lineBit,  // inverted line level
  output uartRxPkg::rxResult_t result
);

  uartRxPkg::byte_t shiftReg;  // bits enter at MSB, LSB arrives first
  uartRxPkg::byte_t dataQ;     // byte handed out with the strobe
  logic             validQ;
  logic             frameErrQ;

  // payload path
  always_ff @(posedge clk)
  begin
    if (shiftEn)
      shiftReg <= {~lineBit, shiftReg[7:1]};  // undo the line inversion
    if (stopEn)
      dataQ <= shiftReg;  // all eight bits are in by now
  end

  // strobes are high for the single clock after stopEn
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      validQ    <= 1'b0;
      frameErrQ <= 1'b0;
    end
    else
    begin
      validQ    <= stopEn && !lineBit;  // stop bit high
      frameErrQ <= stopEn &&  lineBit;  // stop bit low, bad framing
    end
  end

  assign result = '{data: dataQ, valid: validQ, frameErr: frameErrQ};

endmodule

// ==== packetGapDetector.sv ====
`timescale 1ns/1ns
`include "uartRx_params.svh"

module packetGapDetector
(
  input  logic clk,
  input  logic arstN,
  input  logic tick,
  input  logic busy,         // receiver inside a frame
  output logic idle,         // no frame for GAP_TICKS ticks
  output logic endOfPacket   // one clock as idle rises
);

  localparam uartRxPkg::gapCnt_t gapMax = uartRxPkg::gapCnt_t'(`GAP_TICKS);

  uartRxPkg::gapCnt_t gapCnt;

  // starts saturated so no packet end is reported after reset
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      gapCnt      <= gapMax;
      endOfPacket <= 1'b0;
    end
    else
    begin
      if (busy)
        gapCnt <= '0;  // any frame restarts the gap
      else if (tick && (gapCnt != gapMax))
        gapCnt <= gapCnt + 5'd1;

      // fires on the same edge that saturates the counter
      endOfPacket <= tick && !busy && (gapCnt == gapMax - 5'd1);
    end
  end

  assign idle = (gapCnt == gapMax);

endmodule

// ==== uartRxTop.sv ====
`timescale 1ns/1ns

module uartRxTop
(
  input  logic                 clk,
  input  logic                 arstN,
  input  logic                 rx,           // async serial input
  output uartRxPkg::rxResult_t result,       // byte with valid or frameErr strobe
  output logic                 idle,         // line quiet for two bit times
  output logic                 endOfPacket   // burst finished
);

  logic tick;     // 8x oversample tick
  logic lineBit;  // filtered line, high while rx is low
  logic shiftEn;  // data bit sample
  logic stopEn;   // stop bit sample
  logic busy;     // frame in progress

  baudTickGen uBaudTickGen
  (
    .clk   (clk),
    .arstN (arstN),
    .tick  (tick)
  );

  rxLineFilter uRxLineFilter
  (
    .clk     (clk),
    .arstN   (arstN),
    .tick    (tick),
    .rx      (rx),
    .lineBit (lineBit)
  );

  rxFrameFsm uRxFrameFsm
  (
    .clk     (clk),
    .arstN   (arstN),
    .tick    (tick),
    .lineBit (lineBit),
    .shiftEn (shiftEn),
    .stopEn  (stopEn),
    .busy    (busy)
  );

  rxByteShifter uRxByteShifter
  (
    .clk     (clk),
    .arstN   (arstN),
    .shiftEn (shiftEn),
    .stopEn  (stopEn),
    .lineBit (lineBit),
    .result  (result)
  );

  packetGapDetector uPacketGapDetector
  (
    .clk         (clk),
    .arstN       (arstN),
    .tick        (tick),
    .busy        (busy),
    .idle        (idle),
    .endOfPacket (endOfPacket)
  );

endmodule

// ==== uartRx_props.sv ====
`timescale 1ns/1ns

module uartRx_props
(
  input logic                 clk,
  input logic                 arstN,
  input uartRxPkg::rxResult_t result,
  input logic                 busy,         // frame in progress
  input logic                 idle,
  input logic                 endOfPacket
);

  // a frame ends in exactly one of the two strobes
  notBothStrobes: assert property (@(posedge clk) disable iff (!arstN)
    !(result.valid && result.frameErr))
    else $error("valid and frameErr high in the same cycle");

  validOneClock: assert property (@(posedge clk) disable iff (!arstN)
    result.valid |=> !result.valid)
    else $error("valid held for more than one clock");

  frameErrOneClock: assert property (@(posedge clk) disable iff (!arstN)
    result.frameErr |=> !result.frameErr)
    else $error("frameErr held for more than one clock");

  eopOneClock: assert property (@(posedge clk) disable iff (!arstN)
    endOfPacket |=> !endOfPacket)
    else $error("endOfPacket held for more than one clock");

  // reception clears the gap counter, so neither idle nor a packet end can follow
  busyClearsIdle: assert property (@(posedge clk) disable iff (!arstN)
    busy |=> !idle)
    else $error("idle high while a frame is received");

  busyBlocksEop: assert property (@(posedge clk) disable iff (!arstN)
    busy |=> !endOfPacket)
    else $error("endOfPacket during reception");

endmodule

// ==== uartRxTb.sv ====
`timescale 1ns/1ns
`include "uartRx_params.svh"

module uartRxTb;

  localparam int bitClks    = `CLK_FREQ / `BAUD;  // 16 at the defaults
  localparam int frameClks  = 10 * bitClks;       // start, 8 data, stop
  // 15 frames, 40 quiet bits, the hold after the bad frame, gap and glitch waits
  localparam int testClks   = 15 * frameClks + 96 * bitClks;
  localparam int cycleLimit = 2 * testClks + 200;
  localparam int waitLimit  = 3 * frameClks;      // per wait on the DUT

  logic                 clk;
  logic                 arstN;
  logic                 rx;
  uartRxPkg::rxResult_t result;
  logic                 idle;
  logic                 endOfPacket;

  uartRxPkg::rxResult_t results[$];  // every valid or frameErr strobe seen
  int eopCount;
  int valueErrs;                     // wrong values
  int missErrs;                      // results or idle that never came
  int cycles = 0;
  int seed;

  uartRxTop DUT
  (
    .clk         (clk),
    .arstN       (arstN),
    .rx          (rx),
    .result      (result),
    .idle        (idle),
    .endOfPacket (endOfPacket)
  );

  // busy is internal to the top, reached through the bind scope
  bind uartRxTop uartRx_props props
  (
    .clk         (clk),
    .arstN       (arstN),
    .result      (result),
    .busy        (busy),
    .idle        (idle),
    .endOfPacket (endOfPacket)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  // outputs move on rising edges, so sample them on falling ones
  always @(negedge clk)
  begin
    if (arstN)
    begin
      if (result.valid || result.frameErr)
        results.push_back(result);
      if (endOfPacket)
        eopCount++;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: run did not finish within %0d cycles", cycleLimit);
      $display("errors: %0d wrong value, %0d missing", valueErrs, missErrs);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  function automatic uartRxPkg::rxResult_t expectedResult(input uartRxPkg::byte_t data,
                                                          input logic valid,
                                                          input logic frameErr);
    uartRxPkg::rxResult_t r;
    r.data     = data;
    r.valid    = valid;
    r.frameErr = frameErr;
    return r;
  endfunction

  task automatic checkResult(input uartRxPkg::rxResult_t got, input uartRxPkg::rxResult_t exp,
                             input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got data %h valid %b frameErr %b, want data %h valid %b frameErr %b",
               $time, what, got.data, got.valid, got.frameErr, exp.data, exp.valid, exp.frameErr);
      valueErrs++;
    end
  endtask

  task automatic checkByte(input uartRxPkg::byte_t got, input uartRxPkg::byte_t exp,
                           input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      valueErrs++;
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
      valueErrs++;
    end
  endtask

  task automatic checkCount(input int got, input int exp, input string what);
    if (got != exp)
    begin
      $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
      valueErrs++;
    end
  endtask

  task automatic clearRecords();
    results.delete();
    eopCount = 0;
  endtask

  // start bit, data LSB first, stop bit; each held one bit period
  task automatic sendFrame(input uartRxPkg::byte_t data, input logic stopLevel);
    logic [9:0] bits;
    bits = {stopLevel, data, 1'b0};
    for (int i = 0; i < 10; i++)
    begin
      @(posedge clk);
      rx <= bits[i];
      repeat (bitClks - 1) @(posedge clk);
    end
  endtask

  task automatic waitForResults(input int count, input int limit);
    int n;
    n = 0;
    while ((results.size() < count) && (n < limit))
    begin
      @(negedge clk);
      n++;
    end
    if (results.size() < count)
    begin
      $display("missing result: only %0d of %0d frames reported", results.size(), count);
      missErrs++;
    end
  endtask

  task automatic waitForIdle(input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!idle && (n < limit))
    begin
      @(negedge clk);
      n++;
    end
    if (!idle)
    begin
      $display("idle did not return within %0d cycles", limit);
      missErrs++;
    end
  endtask

  task automatic idleAfterReset();
    clearRecords();
    @(negedge clk);
    checkBit(idle, 1'b1, "idle after reset");
    repeat (40 * bitClks) @(negedge clk);  // quiet line for 40 bit times
    checkCount(results.size(), 0, "results on a quiet line");
    checkCount(eopCount, 0, "endOfPacket on a quiet line");
    checkBit(idle, 1'b1, "idle on a quiet line");
  endtask

  task automatic singleByte();
    clearRecords();
    sendFrame(8'hA5, 1'b1);
    waitForResults(1, waitLimit);
    waitForIdle(waitLimit);
    repeat (2) @(negedge clk);  // let the monitor count the pulse
    checkCount(results.size(), 1, "results for one byte");
    if (results.size() > 0)
      checkResult(results[0], expectedResult(8'hA5, 1'b1, 1'b0), "single byte");
    checkCount(eopCount, 1, "endOfPacket after one byte");
    checkBit(idle, 1'b1, "idle after the packet");
  endtask

  task automatic burstOfBytes();
    uartRxPkg::byte_t sent[$];
    uartRxPkg::byte_t b;
    logic [31:0]      r;
    clearRecords();
    for (int i = 0; i < 12; i++)
    begin
      r = $random(seed);
      b = r[7:0];
      sent.push_back(b);
      sendFrame(b, 1'b1);  // next start follows the stop directly
      @(negedge clk);
      checkBit(idle, 1'b0, "idle inside a burst");
    end
    waitForResults(12, waitLimit);
    waitForIdle(waitLimit);
    repeat (2) @(negedge clk);
    checkCount(results.size(), 12, "results for the burst");
    for (int i = 0; (i < results.size()) && (i < 12); i++)
    begin
      checkByte(results[i].data, sent[i], "burst byte");
      checkBit(results[i].valid, 1'b1, "burst valid");
    end
    checkCount(eopCount, 1, "endOfPacket after the burst");
  endtask

  task automatic framingError();
    clearRecords();
    sendFrame(8'h3C, 1'b0);
    @(posedge clk);
    rx <= 1'b1;  // release after a full low stop bit
    // one bit of idle line lets the filter settle high before the next start
    repeat (bitClks) @(posedge clk);
    waitForResults(1, waitLimit);
    sendFrame(8'h5A, 1'b1);
    waitForResults(2, waitLimit);
    waitForIdle(waitLimit);
    repeat (2) @(negedge clk);
    checkCount(results.size(), 2, "results around the bad frame");
    if (results.size() >= 2)
    begin
      checkResult(results[0], expectedResult(8'h3C, 1'b0, 1'b1), "low stop bit");
      checkResult(results[1], expectedResult(8'h5A, 1'b1, 1'b0), "good byte after error");
    end
    checkCount(eopCount, 1, "endOfPacket after the error packet");
  endtask

  task automatic glitchRejection();
    clearRecords();
    for (int i = 0; i < 2; i++)  // second pass lands on the other tick phase
    begin
      @(posedge clk);
      rx <= 1'b0;
      @(posedge clk);
      rx <= 1'b1;
      repeat (bitClks + 1 + i) @(posedge clk);
    end
    repeat (4 * bitClks) @(negedge clk);
    checkCount(results.size(), 0, "results after glitches");
    checkCount(eopCount, 0, "endOfPacket after glitches");
    checkBit(idle, 1'b1, "idle after glitches");
  endtask

  initial
  begin
    seed      = 32'hde3e_4fbc;
    arstN     = 1'b0;
    rx        = 1'b1;  // line idles high
    eopCount  = 0;
    valueErrs = 0;
    missErrs  = 0;
    repeat (5) @(posedge clk);
    arstN <= 1'b1;

    idleAfterReset();
    singleByte();
    burstOfBytes();
    framingError();
    glitchRejection();

    $display("errors: %0d wrong value, %0d missing", valueErrs, missErrs);
    if ((valueErrs == 0) && (missErrs == 0))
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== uartRx.f ====
+incdir+.
uartRxPkg.sv
baudTickGen.sv
rxLineFilter.sv
rxFrameFsm.sv
rxByteShifter.sv
packetGapDetector.sv
uartRxTop.sv
uartRx_props.sv
uartRxTb.sv

// ==== Makefile ====
# Verilator build and run for the UART receiver testbench
VERILATOR ?= verilator
TOP       ?= uartRxTb
FILELIST  ?= uartRx.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) uartRx_params.svh

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# pass only if the log holds the pass line
run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
